// File: source/tcdm_pkg.sv
// ====================
// shared widths and payload types for the TCDM decoupling queue
// imported by the interface, the queues, the decoupler, the bank and the top
// ====================

package tcdm_pkg;

  // word address into the single scratchpad bank
  parameter int unsigned ADDR_W = 10;
  // data word width
  parameter int unsigned DATA_W = 32;
  // one byte enable per data byte
  parameter int unsigned BE_W   = DATA_W / 8;

  // request payload, 47 bits with the default widths
  // wen follows the TCDM convention: high means read, low means write
  typedef struct packed {
    logic [ADDR_W-1:0] add;
    logic              wen;
    logic [BE_W-1:0]   be;
    logic [DATA_W-1:0] data;
  } tcdm_req_t;

  // response payload, reads only
  typedef logic [DATA_W-1:0] tcdm_rsp_t;

  // queue status flags
  typedef struct packed {
    logic empty;
    logic full;
  } fifo_flags_t;

endpackage : tcdm_pkg

// File: source/tcdm_bus_if.sv
// ====================
// TCDM request/grant bus with in-order read responses
// initiator issues requests and back-pressures responses
// target grants requests and returns one r_valid per granted read
// ====================

`timescale 1ns/100ps

interface tcdm_bus_if;

  import tcdm_pkg::*;

  // request channel, transfers when req and gnt are both high
  logic              req;
  logic              gnt;
  logic [ADDR_W-1:0] add;
  // high for a read, low for a write
  logic              wen;
  logic [BE_W-1:0]   be;
  logic [DATA_W-1:0] data;

  // response channel, transfers when r_valid and r_ready are both high
  logic              r_valid;
  tcdm_rsp_t         r_data;
  logic              r_ready;

  // core side or decoupler toward memory
  modport initiator (
    output req,
    output add,
    output wen,
    output be,
    output data,
    output r_ready,
    input  gnt,
    input  r_valid,
    input  r_data
  );

  // decoupler toward core, or the memory bank
  modport target (
    input  req,
    input  add,
    input  wen,
    input  be,
    input  data,
    input  r_ready,
    output gnt,
    output r_valid,
    output r_data
  );

endinterface : tcdm_bus_if

// File: source/stream_fifo.sv
// ====================
// valid/ready circular queue with a selectable payload type
// pop side is registered, an item pushed at edge N is visible after N
// used for both the request and the response direction of the decoupler
// ====================

`timescale 1ns/100ps

module stream_fifo #(
  parameter type         payload_t  = logic [31:0],
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  input  logic                  push_valid_i,
  output logic                  push_ready_o,
  input  payload_t              push_data_i,
  output logic                  pop_valid_o,
  input  logic                  pop_ready_i,
  output payload_t              pop_data_o,
  output tcdm_pkg::fifo_flags_t flags_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  payload_t         mem_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             full;
  logic             empty;
  logic             push;
  logic             pop;

  // pointer advance with explicit wrap
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full  = (count_q == CNT_W'(FIFO_DEPTH));
  assign empty = (count_q == '0);

  // handshakes on both sides
  assign push_ready_o = ~full;
  assign push         = push_valid_i & ~full;
  assign pop_valid_o  = ~empty;
  assign pop          = pop_ready_i & ~empty;

  // head of queue straight from storage, no fall-through
  assign pop_data_o = mem_q[rd_ptr_q];

  // pointers and occupancy
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else if (clear_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      // simultaneous push and pop leaves the count alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  // payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  assign flags_o.empty = empty;
  assign flags_o.full  = full;

endmodule : stream_fifo

// File: source/tcdm_decoupler.sv
// ====================
// TCDM request/response decoupler
// core requests go through an outgoing queue toward memory
// read data comes back through an incoming queue, in order
// memory requests are issued only while the incoming queue has room
// ====================

`timescale 1ns/100ps

module tcdm_decoupler #(
  parameter int unsigned FIFO_DEPTH = 4
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  clear_i,
  tcdm_bus_if.target            core,
  tcdm_bus_if.initiator         mem,
  output tcdm_pkg::fifo_flags_t flags_o
);

  import tcdm_pkg::*;

  // outgoing stream
  tcdm_req_t   req_push_data;
  tcdm_req_t   req_pop_data;
  logic        req_pop_valid;
  fifo_flags_t req_flags;

  // incoming stream
  logic        rsp_push_valid;
  logic        rsp_push_ready;
  tcdm_rsp_t   rsp_push_data;
  fifo_flags_t rsp_flags;

  // one-entry hold for a response the incoming queue refused
  logic        hold_q;
  tcdm_rsp_t   hold_data_q;
  logic        live_taken;
  logic        hold_load;

  // read granted last cycle, its data is on the bus now
  logic        rd_pend_q;

  // ====================
  // outgoing side
  // ====================

  // pack the core request fields
  assign req_push_data.add  = core.add;
  assign req_push_data.wen  = core.wen;
  assign req_push_data.be   = core.be;
  assign req_push_data.data = core.data;

  stream_fifo #(
    .payload_t  ( tcdm_req_t ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_req_fifo (
    .clk_i        ( clk_i         ),
    .rst_ni       ( rst_ni        ),
    .clear_i      ( clear_i       ),
    .push_valid_i ( core.req      ),
    .push_ready_o ( core.gnt      ),
    .push_data_i  ( req_push_data ),
    .pop_valid_o  ( req_pop_valid ),
    .pop_ready_i  ( mem.gnt       ),
    .pop_data_o   ( req_pop_data  ),
    .flags_o      ( req_flags     )
  );

  // the bank cannot stall its responses, so hold off while no room is left
  // gnt needs req, so a low req also keeps the queue head in place
  assign mem.req  = req_pop_valid & rsp_push_ready;
  assign mem.add  = req_pop_data.add;
  assign mem.wen  = req_pop_data.wen;
  assign mem.be   = req_pop_data.be;
  assign mem.data = req_pop_data.data;
  assign mem.r_ready = rsp_push_ready;

  // ====================
  // incoming side
  // ====================

  // held response is older, so it goes first
  assign rsp_push_valid = hold_q | mem.r_valid;
  assign rsp_push_data  = hold_q ? hold_data_q : mem.r_data;

  // live response goes straight in only when nothing is held
  assign live_taken = mem.r_valid & ~hold_q & rsp_push_ready;
  assign hold_load  = mem.r_valid & ~live_taken;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      hold_q <= 1'b0;
    end else if (clear_i) begin
      hold_q <= 1'b0;
    end else begin
      // held entry stays until the queue accepts it
      hold_q <= (hold_q & ~rsp_push_ready) | hold_load;
    end
  end

  always_ff @(posedge clk_i) begin
    if (hold_load) begin
      hold_data_q <= mem.r_data;
    end
  end

  stream_fifo #(
    .payload_t  ( tcdm_rsp_t ),
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_rsp_fifo (
    .clk_i        ( clk_i          ),
    .rst_ni       ( rst_ni         ),
    .clear_i      ( clear_i        ),
    .push_valid_i ( rsp_push_valid ),
    .push_ready_o ( rsp_push_ready ),
    .push_data_i  ( rsp_push_data  ),
    .pop_valid_o  ( core.r_valid   ),
    .pop_ready_i  ( core.r_ready   ),
    .pop_data_o   ( core.r_data    ),
    .flags_o      ( rsp_flags      )
  );

  // track the read whose data is one cycle away
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_pend_q <= 1'b0;
    end else if (clear_i) begin
      rd_pend_q <= 1'b0;
    end else begin
      rd_pend_q <= mem.req & mem.gnt & mem.wen;
    end
  end

  // idle only when nothing is queued, held or on its way back
  assign flags_o.empty = req_flags.empty & rsp_flags.empty & ~hold_q & ~rd_pend_q;
  // full refers to the core side, where gnt drops
  assign flags_o.full  = req_flags.full;

endmodule : tcdm_decoupler

// File: source/tcdm_bank.sv
// ====================
// single-port scratchpad bank on the TCDM target side
// grants every request unless stalled, writes per byte enable
// read data returns one cycle after the grant, contents zero after reset
// ====================

`timescale 1ns/100ps

module tcdm_bank #(
  parameter int unsigned BANK_WORDS = 1024
) (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       stall_i,
  tcdm_bus_if.target bus
);

  import tcdm_pkg::*;

  localparam int unsigned IDX_W = (BANK_WORDS > 1) ? $clog2(BANK_WORDS) : 1;

  logic [DATA_W-1:0] mem_q [BANK_WORDS];
  logic [IDX_W-1:0]  idx;
  logic              gnt;
  logic              wr_en;
  logic              rd_en;
  logic              r_valid_q;
  tcdm_rsp_t         r_data_q;

  // stall models losing arbitration against other initiators
  assign gnt     = bus.req & ~stall_i;
  assign bus.gnt = gnt;

  // low address bits pick the word
  assign idx = bus.add[IDX_W-1:0];

  // wen high is a read
  assign wr_en = gnt & ~bus.wen;
  assign rd_en = gnt & bus.wen;

  // ====================
  // storage
  // ====================

  // array cleared by reset, written only where be is set
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int w = 0; w < BANK_WORDS; w++) begin
        mem_q[w] <= '0;
      end
    end else if (wr_en) begin
      for (int b = 0; b < BE_W; b++) begin
        if (bus.be[b]) begin
          mem_q[idx][8*b +: 8] <= bus.data[8*b +: 8];
        end
      end
    end
  end

  // ====================
  // read path
  // ====================

  // valid for exactly one cycle per granted read
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= rd_en;
    end
  end

  // read data register, only loaded on a read
  always_ff @(posedge clk_i) begin
    if (rd_en) begin
      r_data_q <= mem_q[idx];
    end
  end

  assign bus.r_valid = r_valid_q;
  assign bus.r_data  = r_data_q;

endmodule : tcdm_bank

// File: source/tcdm_fifo_top.sv
// ====================
// top level of the TCDM decoupling queue
// plain core ports in, decoupler in the middle, one scratchpad bank behind
// wen_i high requests a read, low a byte-enabled write
// ====================

`timescale 1ns/100ps

module tcdm_fifo_top #(
  parameter int unsigned FIFO_DEPTH = 4,
  parameter int unsigned BANK_WORDS = 1024
) (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  input  logic                          clear_i,
  input  logic                          stall_i,
  input  logic                          req_i,
  output logic                          gnt_o,
  input  logic [tcdm_pkg::ADDR_W-1:0]   add_i,
  input  logic                          wen_i,
  input  logic [tcdm_pkg::BE_W-1:0]     be_i,
  input  logic [tcdm_pkg::DATA_W-1:0]   data_i,
  output logic                          r_valid_o,
  output tcdm_pkg::tcdm_rsp_t           r_data_o,
  input  logic                          r_ready_i,
  output logic                          empty_o
);

  import tcdm_pkg::*;

  fifo_flags_t dec_flags;

  // core side and memory side buses
  tcdm_bus_if core_bus ();
  tcdm_bus_if mem_bus ();

  // core port onto the bus
  assign core_bus.req     = req_i;
  assign core_bus.add     = add_i;
  assign core_bus.wen     = wen_i;
  assign core_bus.be      = be_i;
  assign core_bus.data    = data_i;
  assign core_bus.r_ready = r_ready_i;
  assign gnt_o            = core_bus.gnt;
  assign r_valid_o        = core_bus.r_valid;
  assign r_data_o         = core_bus.r_data;

  tcdm_decoupler #(
    .FIFO_DEPTH ( FIFO_DEPTH )
  ) u_decoupler (
    .clk_i   ( clk_i     ),
    .rst_ni  ( rst_ni    ),
    .clear_i ( clear_i   ),
    .core    ( core_bus  ),
    .mem     ( mem_bus   ),
    .flags_o ( dec_flags )
  );

  tcdm_bank #(
    .BANK_WORDS ( BANK_WORDS )
  ) u_bank (
    .clk_i   ( clk_i   ),
    .rst_ni  ( rst_ni  ),
    .stall_i ( stall_i ),
    .bus     ( mem_bus )
  );

  assign empty_o = dec_flags.empty;

endmodule : tcdm_fifo_top

// File: verification/tb_clock_gen.sv
// ====================
// testbench clock and power-on reset
// reset is held low for RST_CYCLES rising edges and released on a falling edge
// ====================

`timescale 1ns/100ps

module tb_clock_gen #(
  parameter int unsigned PERIOD_NS  = 40,
  parameter int unsigned RST_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no = 1'b1;
  end

endmodule : tb_clock_gen

// File: verification/tcdm_fifo_checker.sv
// ====================
// protocol assertions on the core port of the TCDM decoupling queue
// bound into the top level, port names match the top so .* connects them
// ====================

`timescale 1ns/100ps

module tcdm_fifo_checker (
  input logic                        clk_i,
  input logic                        rst_ni,
  input logic                        clear_i,
  input logic                        req_i,
  input logic                        gnt_o,
  input logic [tcdm_pkg::ADDR_W-1:0] add_i,
  input logic                        wen_i,
  input logic [tcdm_pkg::BE_W-1:0]   be_i,
  input logic [tcdm_pkg::DATA_W-1:0] data_i,
  input logic                        r_valid_o,
  input logic                        r_ready_i,
  input logic                        empty_o
);

  // accepted reads whose data has not yet been taken by the core
  int rd_out_q;
  int fail_count = 0;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_out_q <= 0;
    end else if (clear_i) begin
      rd_out_q <= 0;
    end else begin
      rd_out_q <= rd_out_q + int'(req_i && gnt_o && wen_i) - int'(r_valid_o && r_ready_i);
    end
  end

  // a waiting request keeps req and all of its fields
  hold_fields: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i && !gnt_o |=> req_i && $stable({add_i, wen_i, be_i, data_i}))
    else begin
      $error("request changed while waiting for grant");
      fail_count++;
    end

  no_rsp_in_reset: assert property (@(posedge clk_i) !rst_ni |-> !r_valid_o)
    else begin
      $error("response valid during reset");
      fail_count++;
    end

  // empty_o high means no read is outstanding
  busy_not_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rd_out_q != 0 |-> !empty_o)
    else begin
      $error("empty flag high with reads outstanding");
      fail_count++;
    end

endmodule : tcdm_fifo_checker

bind tcdm_fifo_top tcdm_fifo_checker u_checker (.*);

// File: verification/tcdm_fifo_tb.sv
// ====================
// testbench for the TCDM decoupling queue
// operations, back-pressure codes and expected read data come from the data file
// read data is checked in order against a scoreboard queue
// ====================

`timescale 1ns/100ps

module tcdm_fifo_tb;

  import tcdm_pkg::*;

  localparam int unsigned FIFO_DEPTH = 4;
  localparam int unsigned BANK_WORDS = 1024;
  // eight words per record: test op addr be data stall ready expect
  localparam int unsigned REC_W      = 8;
  localparam int unsigned MAX_OPS    = 64;

  logic              clk;
  logic              rst_n;
  logic              clear;
  logic              stall;
  logic              req;
  logic              gnt;
  logic [ADDR_W-1:0] add;
  logic              wen;
  logic [BE_W-1:0]   be;
  logic [DATA_W-1:0] data;
  logic              r_valid;
  tcdm_rsp_t         r_data;
  logic              r_ready;
  logic              empty;

  logic [31:0]       recs [REC_W*MAX_OPS];
  logic [DATA_W-1:0] model [BANK_WORDS];
  tcdm_rsp_t         sb_q [$];
  int                n_ops;
  int                checks;
  int                errors;
  int                test_errors;
  int                cycles;
  int                cycle_limit;
  int                seed;
  int                stall_cnt;
  int                ready_cnt;
  bit                stall_rnd;
  bit                ready_rnd;

  tb_clock_gen #(
    .PERIOD_NS  ( 40 ),
    .RST_CYCLES ( 3  )
  ) u_clock_gen (
    .clk_o  ( clk   ),
    .rst_no ( rst_n )
  );

  tcdm_fifo_top #(
    .FIFO_DEPTH ( FIFO_DEPTH ),
    .BANK_WORDS ( BANK_WORDS )
  ) u_tcdm_fifo_top (
    .clk_i     ( clk     ),
    .rst_ni    ( rst_n   ),
    .clear_i   ( clear   ),
    .stall_i   ( stall   ),
    .req_i     ( req     ),
    .gnt_o     ( gnt     ),
    .add_i     ( add     ),
    .wen_i     ( wen     ),
    .be_i      ( be      ),
    .data_i    ( data    ),
    .r_valid_o ( r_valid ),
    .r_data_o  ( r_data  ),
    .r_ready_i ( r_ready ),
    .empty_o   ( empty   )
  );

  // ====================
  // compare tasks
  // ====================

  task automatic check_rsp(input tcdm_rsp_t act, input tcdm_rsp_t exp);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("MISMATCH at %0t ns: read data expected %h, got %h", $time, exp, act);
    end
  endtask

  task automatic check_flag(input string what, input logic act, input logic exp);
    checks++;
    if (act !== exp) begin
      errors++;
      test_errors++;
      $display("MISMATCH at %0t ns: %s expected %b, got %b", $time, what, exp, act);
    end
  endtask

  // ====================
  // back-pressure patterns
  // ====================

  // 00 keeps the pattern, fe ends it, ff random, else asserted for that many cycles
  task automatic load_pattern(input logic [7:0] code, inout int cnt, inout bit rnd_on);
    if (code == 8'hff) begin
      rnd_on = 1'b1;
      cnt    = 0;
    end else if (code == 8'hfe) begin
      rnd_on = 1'b0;
      cnt    = 0;
    end else if (code != 8'h00) begin
      rnd_on = 1'b0;
      cnt    = code;
    end
  endtask

  task automatic step_pressure(inout int cnt, input bit rnd_on, output logic level);
    int rnd;
    rnd = $random(seed);
    if (cnt > 0) begin
      cnt--;
      level = 1'b1;
    end else begin
      level = rnd_on & rnd[0];
    end
  endtask

  // all inputs change on the falling edge
  task automatic next_cycle();
    logic lvl;
    @(negedge clk);
    step_pressure(stall_cnt, stall_rnd, lvl);
    stall = lvl;
    step_pressure(ready_cnt, ready_rnd, lvl);
    r_ready = ~lvl;
  endtask

  // ====================
  // operations
  // ====================

  task automatic issue(input logic [ADDR_W-1:0] a, input logic rd, input logic [BE_W-1:0] b,
                       input logic [DATA_W-1:0] d, input tcdm_rsp_t exp, input bit blocked);
    logic granted;
    req  = 1'b1;
    add  = a;
    wen  = rd;
    be   = b;
    data = d;
    if (blocked) begin
      check_flag("gnt_o with the request queue full", gnt, 1'b0);
    end
    granted = 1'b0;
    while (!granted) begin
      @(posedge clk);
      granted = gnt;
      if (granted && rd) begin
        sb_q.push_back(exp);
      end
      next_cycle();
    end
    req = 1'b0;
  endtask

  task automatic pulse_clear();
    clear = 1'b1;
    @(posedge clk);
    // reads still queued are dropped by the clear
    sb_q.delete();
    next_cycle();
    clear = 1'b0;
  endtask

  task automatic drain();
    while (sb_q.size() != 0 || !empty) begin
      next_cycle();
    end
  endtask

  task automatic report_test(input int t);
    if (test_errors == 0) begin
      $display("test %0d: ok", t);
    end else begin
      $display("test %0d: %0d error(s)", t, test_errors);
    end
  endtask

  // response monitor, samples on the rising edge where the transfer happens
  always @(posedge clk) begin
    if (rst_n && r_valid && r_ready) begin
      if (sb_q.size() == 0) begin
        errors++;
        test_errors++;
        $display("response at %0t ns arrived with no read outstanding", $time);
      end else begin
        check_rsp(r_data, sb_q.pop_front());
      end
    end
  end

  // run limit from the number of operations
  always @(posedge clk) begin
    cycles++;
    if (cycle_limit > 0 && cycles > cycle_limit) begin
      $display("run timed out after %0d cycles", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    int          base;
    int          cur_test;
    logic [7:0]  op;
    logic [ADDR_W-1:0] a;
    logic [BE_W-1:0]   b;
    logic [DATA_W-1:0] d;
    tcdm_rsp_t   exp;
    seed        = 32'h0208_96e9;
    clear       = 1'b0;
    stall       = 1'b0;
    req         = 1'b0;
    add         = '0;
    wen         = 1'b0;
    be          = '0;
    data        = '0;
    r_ready     = 1'b1;
    checks      = 0;
    errors      = 0;
    test_errors = 0;
    cycles      = 0;
    stall_cnt   = 0;
    ready_cnt   = 0;
    stall_rnd   = 1'b0;
    ready_rnd   = 1'b0;
    for (int i = 0; i < REC_W * MAX_OPS; i++) begin
      recs[i] = '1;
    end
    for (int w = 0; w < BANK_WORDS; w++) begin
      model[w] = '0;
    end
    $readmemh("verification/tcdm_fifo_testdata.txt", recs);
    n_ops = 0;
    while (n_ops < MAX_OPS && recs[REC_W*n_ops] !== '1) begin
      n_ops++;
    end
    cycle_limit = 40 * n_ops + 100;

    @(posedge rst_n);
    next_cycle();
    cur_test = 0;
    for (int i = 0; i < n_ops; i++) begin
      base = REC_W * i;
      if (recs[base] != cur_test) begin
        if (cur_test != 0) begin
          report_test(cur_test);
        end
        cur_test    = recs[base];
        test_errors = 0;
      end
      op  = recs[base+1][7:0];
      a   = recs[base+2][ADDR_W-1:0];
      b   = recs[base+3][BE_W-1:0];
      d   = recs[base+4];
      exp = recs[base+7];
      // a drain line keeps the running patterns until the queues are empty
      if (op != 8'd5) begin
        load_pattern(recs[base+5][7:0], stall_cnt, stall_rnd);
        load_pattern(recs[base+6][7:0], ready_cnt, ready_rnd);
      end
      case (op)
        8'd0: begin
          for (int k = 0; k < BE_W; k++) begin
            if (b[k]) begin
              model[a][8*k +: 8] = d[8*k +: 8];
            end
          end
          issue(a, 1'b0, b, d, '0, 1'b0);
        end
        8'd1, 8'd4: begin
          if (model[a] !== exp) begin
            errors++;
            test_errors++;
            $display("data file expects %h at address %h but the model holds %h",
                     exp, a, model[a]);
          end
          issue(a, 1'b1, b, d, exp, op == 8'd4);
        end
        8'd2: pulse_clear();
        8'd3: begin
          check_flag("empty_o", empty, exp[0]);
          if (exp[0]) begin
            check_flag("r_valid_o while idle", r_valid, 1'b0);
          end
        end
        8'd5: begin
          drain();
          load_pattern(recs[base+5][7:0], stall_cnt, stall_rnd);
          load_pattern(recs[base+6][7:0], ready_cnt, ready_rnd);
        end
        default: begin
          errors++;
          $display("record %0d holds an unknown operation code %h", i, op);
        end
      endcase
    end
    report_test(cur_test);
    load_pattern(8'hfe, stall_cnt, stall_rnd);
    load_pattern(8'hfe, ready_cnt, ready_rnd);
    drain();

    $display("%0d checks, %0d errors, %0d assertion failures",
             checks, errors, u_tcdm_fifo_top.u_checker.fail_count);
    if (errors == 0 && u_tcdm_fifo_top.u_checker.fail_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : tcdm_fifo_tb

// File: tcdm_fifo.f
source/tcdm_pkg.sv
source/tcdm_bus_if.sv
source/stream_fifo.sv
source/tcdm_decoupler.sv
source/tcdm_bank.sv
source/tcdm_fifo_top.sv
verification/tb_clock_gen.sv
verification/tcdm_fifo_checker.sv
verification/tcdm_fifo_tb.sv

// File: verification/tcdm_fifo_testdata.txt
// test op addr be data stall ready expect, all hex, one operation per line
// op 0 write, 1 read, 2 clear, 3 empty check, 4 read into a full queue, 5 drain
// stall/ready 00 keep, fe off, ff random, other values hold for that many cycles
01 3 000 0 00000000 00 00 00000001
01 1 005 f 00000000 00 00 00000000
01 1 3ff f 00000000 00 00 00000000
01 5 000 0 00000000 00 00 00000000
02 0 010 f 11223344 00 00 00000000
02 0 011 f a5a5a5a5 00 00 00000000
02 0 012 f deadbeef 00 00 00000000
02 1 012 f 00000000 00 00 deadbeef
02 1 010 f 00000000 00 00 11223344
02 1 011 f 00000000 00 00 a5a5a5a5
02 5 000 0 00000000 00 00 00000000
03 0 020 f 01234567 00 00 00000000
03 0 020 5 ffeeddcc 00 00 00000000
03 1 020 f 00000000 00 00 01ee45cc
03 0 020 a 99887766 00 00 00000000
03 1 020 f 00000000 00 00 99ee77cc
03 5 000 0 00000000 00 00 00000000
04 1 010 f 00000000 0c 00 11223344
04 1 011 f 00000000 00 00 a5a5a5a5
04 1 012 f 00000000 00 00 deadbeef
04 1 020 f 00000000 00 00 99ee77cc
04 4 005 f 00000000 00 00 00000000
04 5 000 0 00000000 00 00 00000000
05 1 010 f 00000000 ff 30 11223344
05 1 011 f 00000000 00 00 a5a5a5a5
05 1 012 f 00000000 00 00 deadbeef
05 1 020 f 00000000 00 00 99ee77cc
05 1 3ff f 00000000 00 00 00000000
05 1 011 f 00000000 00 00 a5a5a5a5
05 1 010 f 00000000 00 00 11223344
05 5 000 0 00000000 fe fe 00000000
06 0 030 f cafef00d 00 00 00000000
06 5 000 0 00000000 00 00 00000000
06 1 030 f 00000000 10 00 cafef00d
06 1 010 f 00000000 00 00 11223344
06 3 000 0 00000000 00 00 00000000
06 2 000 0 00000000 00 00 00000000
06 3 000 0 00000000 00 00 00000001
06 1 030 f 00000000 00 00 cafef00d
06 5 000 0 00000000 fe fe 00000000
